/* display_scan.sv */
`timescale 1ns/1ns
`default_nettype none

module display_scan #(
    parameter int scan_div = 16384
) (
    input  logic            clk,
    input  logic            rst,
    input  vend_pkg::disp_t nums,
    output logic [6:0]      seg,
    output logic [3:0]      digit
);
    import vend_pkg::*;

    localparam int div_w = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam logic [div_w-1:0] div_last = div_w'(scan_div - 1);

    logic [div_w-1:0] div_cnt;
    logic [1:0]       sel;
    bcd_t             cur;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            sel     <= 2'd0;
        end else if (div_cnt == div_last) begin
            div_cnt <= '0;
            sel     <= sel + 2'd1;  // next digit
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign cur   = nums[{sel, 2'b00} +: 4];
    assign digit = ~(4'b0001 << sel);  // one-cold

    // segments g..a, low lights
    always_comb begin
        case (cur)
            4'd0:        seg = 7'b1000000;
            4'd1:        seg = 7'b1111001;
            4'd2:        seg = 7'b0100100;
            4'd3:        seg = 7'b0110000;
            4'd4:        seg = 7'b0011001;
            4'd5:        seg = 7'b0010010;
            4'd6:        seg = 7'b0000010;
            4'd7:        seg = 7'b1111000;
            4'd8:        seg = 7'b0000000;
            4'd9:        seg = 7'b0010000;
            digit_minus: seg = 7'b0111111;
            default:     seg = 7'b1111111;
        endcase
    end

endmodule

`default_nettype wire

/* key_map.sv */
`timescale 1ns/1ns
`default_nettype none

module key_map (
    input  logic                clk,
    input  logic                rst,
    input  logic                key_valid,
    input  logic [8:0]          key_code,
    output logic                key_event,
    output vend_pkg::key_kind_t key_kind,
    output vend_pkg::bcd_t      key_digit
);
    import vend_pkg::*;

    // main row 0..9, then numeric pad 0..9
    localparam logic [8:0] digit_codes [20] = '{
        9'h045, 9'h016, 9'h01e, 9'h026, 9'h025,
        9'h02e, 9'h036, 9'h03d, 9'h03e, 9'h046,
        9'h070, 9'h069, 9'h072, 9'h07a, 9'h06b,
        9'h073, 9'h074, 9'h06c, 9'h075, 9'h07d
    };
    localparam logic [8:0] enter_code = 9'h05a;
    localparam logic [8:0] space_code = 9'h029;

    key_kind_t kind_lookup;
    bcd_t      digit_lookup;

    always_comb begin
        kind_lookup  = kind_none;
        digit_lookup = '0;
        for (int i = 0; i < 20; i++) begin
            if (key_code == digit_codes[i]) begin
                kind_lookup  = kind_digit;
                digit_lookup = bcd_t'(i % 10);  // both rows give same digit
            end
        end
        if (key_code == enter_code) kind_lookup = kind_enter;
        if (key_code == space_code) kind_lookup = kind_space;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_event <= 1'b0;
            key_kind  <= kind_none;
        end else begin
            key_event <= key_valid && (kind_lookup != kind_none);  // unknown codes dropped
            if (key_valid && (kind_lookup != kind_none)) key_kind <= kind_lookup;
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid) key_digit <= digit_lookup;
    end

    // framed codes arrive far apart, so events never merge
    assert property (@(posedge clk) disable iff (rst) key_event |=> !key_event);

endmodule

`default_nettype wire

/* purchase_calc.sv */
`timescale 1ns/1ns
`default_nettype none

module purchase_calc (
    input  logic                  clk,
    input  logic                  rst,
    input  vend_pkg::vend_state_t state,
    input  vend_pkg::money_t      price,
    input  vend_pkg::bcd_t        stock,
    input  vend_pkg::money_t      paid,
    output vend_pkg::bcd_t        quantity,
    output logic [7:0]            spent_bcd,
    output logic [7:0]            change_bcd
);
    import vend_pkg::*;

    bcd_t       q_best;
    logic [9:0] cost;     // up to 9 x 99
    money_t     spent_next;
    money_t     spent;
    money_t     change;

    // largest count the stock and the payment both allow
    always_comb begin
        q_best = '0;
        for (int q = 1; q <= 9; q++) begin
            if (bcd_t'(q) <= stock && 10'(q) * {3'b0, price} <= {3'b0, paid}) begin
                q_best = bcd_t'(q);
            end
        end
    end

    assign cost       = {6'b0, q_best} * {3'b0, price};
    assign spent_next = money_t'(cost);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quantity <= '0;
            spent    <= '0;
            change   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    quantity <= '0;
                    spent    <= '0;
                    change   <= '0;
                end
                st_buy: begin
                    quantity <= q_best;
                    spent    <= spent_next;
                    change   <= paid - spent_next;
                end
                st_change: begin
                    change <= paid - spent;  // refund keeps spent at zero
                end
                default: begin
                    quantity <= quantity;
                end
            endcase
        end
    end

    assign spent_bcd  = money_to_bcd(spent);
    assign change_bcd = money_to_bcd(change);

    // paid is frozen in the controller while a sale is on
    assert property (@(posedge clk) disable iff (rst) spent <= paid);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the vending controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_vend -f vlog.f

./obj_dir/Vtb_vend | tee sim.log

grep -qF '*** PASSED ***' sim.log
echo "simulation passed"

/* tb_vend.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_vend;

    localparam int blink_cycles  = 8;
    localparam int change_cycles = 20;
    localparam int scan_div      = 2;
    localparam int settle_cycles = 4;  // edge or key pipeline, then the display register
    localparam int op_budget     = change_cycles + 6 * blink_cycles + 100;

    logic        clk;
    logic        rst;
    logic        btn_set;
    logic        btn_pay;
    logic        key_valid;
    logic [8:0]  key_code;
    logic [6:0]  seg;
    logic [3:0]  digit;
    logic [15:0] led;

    string       op_kind [$];
    string       op_name [$];
    int          op_code [$];
    logic [15:0] op_disp [$];
    logic [15:0] op_led  [$];
    bit          loaded;
    int          n_pass;
    int          n_fail;

    vend_top #(
        .blink_cycles(blink_cycles),
        .change_cycles(change_cycles),
        .scan_div(scan_div)
    ) i_dut (
        .clk(clk), .rst(rst), .btn_set(btn_set), .btn_pay(btn_pay),
        .key_valid(key_valid), .key_code(key_code),
        .seg(seg), .digit(digit), .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        wait (loaded);
        repeat ((op_kind.size() + 1) * op_budget) @(posedge clk);
        $display("timeout: the operations did not finish in the allotted cycles");
        $display("*** FAILED ***");
        $finish;
    end

    // active low segments g..a back to a digit code
    function automatic logic [3:0] seg_to_code(input logic [6:0] s);
        case (s)
            7'b1000000: return 4'h0;
            7'b1111001: return 4'h1;
            7'b0100100: return 4'h2;
            7'b0110000: return 4'h3;
            7'b0011001: return 4'h4;
            7'b0010010: return 4'h5;
            7'b0000010: return 4'h6;
            7'b1111000: return 4'h7;
            7'b0000000: return 4'h8;
            7'b0010000: return 4'h9;
            7'b0111111: return 4'ha;  // middle bar only
            7'b1111111: return 4'hb;
            default:    return 4'hf;  // not a legal pattern
        endcase
    endfunction

    task automatic load_ops();
        int    fd;
        int    code;
        int    d3;
        int    d2;
        int    d1;
        int    d0;
        int    led_exp;
        string line;
        string kind;
        string name;
        fd = $fopen("tb_vend_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            n_fail++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            kind = "";
            name = "";
            code = 0;
            void'($fgets(line, fd));
            if ($sscanf(line, "%s", kind) < 1) continue;
            if (kind.substr(0, 0) == "#") continue;  // column notes
            if (kind == "key") begin
                void'($sscanf(line, "%s %h", kind, code));
            end else if (kind == "check") begin
                void'($sscanf(line, "%s %s %h %h %h %h %h", kind, name, d3, d2, d1, d0,
                              led_exp));
            end
            op_kind.push_back(kind);
            op_name.push_back(name);
            op_code.push_back(code);
            op_disp.push_back({d3[3:0], d2[3:0], d1[3:0], d0[3:0]});
            op_led.push_back(led_exp[15:0]);
        end
        $fclose(fd);
    endtask

    task automatic idle_gap();
        repeat (1 + $urandom % 4) @(posedge clk);
    endtask

    task automatic wait_for_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (led !== 16'h0000 && waited < op_budget) begin
            @(negedge clk);
            waited++;
        end
        if (led !== 16'h0000) begin
            $display("the machine did not return to idle, LEDs stay at %h", led);
            n_fail++;
        end
    endtask

    // one full scan, each digit picked up while its select is low
    task automatic check_display(input int idx);
        logic [15:0] shown;
        logic [15:0] led_seen;
        bit          bad_select;
        shown      = 16'hffff;
        bad_select = 1'b0;
        repeat (settle_cycles) @(posedge clk);
        @(negedge clk);
        led_seen = led;
        for (int c = 0; c < 4 * scan_div; c++) begin
            case (digit)
                4'b1110: shown[3:0]   = seg_to_code(seg);
                4'b1101: shown[7:4]   = seg_to_code(seg);
                4'b1011: shown[11:8]  = seg_to_code(seg);
                4'b0111: shown[15:12] = seg_to_code(seg);
                default: bad_select   = 1'b1;
            endcase
            @(negedge clk);
        end
        if (bad_select) begin
            $display("%s: the digit select was not one-cold during the scan", op_name[idx]);
            n_fail++;
        end else if (shown !== op_disp[idx] || led_seen !== op_led[idx]) begin
            $display("[ERROR] %s: expected display %h led %h, actual display %h led %h",
                     op_name[idx], op_disp[idx], op_led[idx], shown, led_seen);
            n_fail++;
        end else begin
            $display("ok %s: display %h led %h", op_name[idx], shown, led_seen);
            n_pass++;
        end
    endtask

    task automatic run_op(input int idx);
        if (op_kind[idx] == "btn_set") begin
            idle_gap();
            btn_set <= 1'b1;
            @(posedge clk);
            btn_set <= 1'b0;
        end else if (op_kind[idx] == "btn_pay") begin
            idle_gap();
            btn_pay <= 1'b1;
            @(posedge clk);
            btn_pay <= 1'b0;
        end else if (op_kind[idx] == "key") begin
            idle_gap();
            key_code  <= 9'(op_code[idx]);
            key_valid <= 1'b1;
            @(posedge clk);
            key_valid <= 1'b0;
        end else if (op_kind[idx] == "wait_buy") begin
            repeat (6 * blink_cycles) @(posedge clk);  // blink phase has a fixed length
        end else if (op_kind[idx] == "wait_idle") begin
            wait_for_idle();
        end else if (op_kind[idx] == "check") begin
            check_display(idx);
        end else begin
            $display("unknown operation '%s' in the test data", op_kind[idx]);
            n_fail++;
        end
    endtask

    initial begin
        rst       = 1'b1;
        btn_set   = 1'b0;
        btn_pay   = 1'b0;
        key_valid = 1'b0;
        key_code  = 9'h000;
        loaded    = 1'b0;
        n_pass    = 0;
        n_fail    = 0;
        void'($urandom(26143));
        load_ops();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < op_kind.size(); i++) begin
            run_op(i);
        end
        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_vend_testdata.txt */
# op: btn_set | btn_pay | key <scan code hex> | wait_buy | wait_idle
# check <name> <four digit codes left to right, a minus, b blank> <led hex>
check reset_idle a a a a 0000
btn_set
check set_entry 9 a 1 0 ff00
key 016
check stock_main_row 1 a 1 0 ff00
key 07d
check stock_keypad 9 a 1 0 ff00
key 029
key 01e
key 073
check price_25 9 a 2 5 00ff
key 05a
check set_exit a a a a 0000
btn_pay
key 026
key 026
key 01e
check pay_25 b b 2 5 0000
key 025
key 025
check pay_saturate b b 9 9 0000
key 045
check pay_clear b b 0 0 0000
key 025
key 026
check pay_60 b b 6 0 0000
key 05a
wait_buy
check sale_change 2 a 1 0 ffff
wait_idle
btn_set
check stock_after_sale 7 a 2 5 ff00
key 05a
btn_pay
key 01e
key 05a
check refund_short 0 a 0 5 ffff
wait_idle
btn_set
key 045
key 05a
btn_pay
key 025
key 05a
check refund_empty 0 a 5 0 ffff
wait_idle
check end_idle a a a a 0000

/* vend_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module vend_ctrl #(
    parameter int blink_cycles  = 25_000_000,
    parameter int change_cycles = 150_000_000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  btn_set,
    input  logic                  btn_pay,
    input  logic                  key_event,
    input  vend_pkg::key_kind_t   key_kind,
    input  vend_pkg::bcd_t        key_digit,
    input  vend_pkg::bcd_t        quantity,
    input  logic [7:0]            spent_bcd,
    input  logic [7:0]            change_bcd,
    output vend_pkg::vend_state_t state,
    output vend_pkg::money_t      price,
    output vend_pkg::bcd_t        stock,
    output vend_pkg::money_t      paid,
    output vend_pkg::disp_t       nums,
    output logic [15:0]           led
);
    import vend_pkg::*;

    localparam int cnt_max = (blink_cycles > change_cycles) ? blink_cycles : change_cycles;
    localparam int cnt_w   = $clog2(cnt_max + 1);
    localparam logic [cnt_w-1:0] blink_last  = cnt_w'(blink_cycles - 1);
    localparam logic [cnt_w-1:0] change_last = cnt_w'(change_cycles - 1);

    logic             set_d, pay_d;
    logic             set_rise, pay_rise;
    logic             price_field;  // 0 edits stock, 1 edits price
    logic [cnt_w-1:0] cnt;
    logic [2:0]       phase;        // blink half-period index
    logic             digit_hit, enter_hit, space_hit;
    logic [7:0]       coin_sum;
    money_t           price_shift;
    logic [7:0]       price_bcd, paid_bcd;

    assign digit_hit = key_event && (key_kind == kind_digit);
    assign enter_hit = key_event && (key_kind == kind_enter);
    assign space_hit = key_event && (key_kind == kind_space);

    assign coin_sum    = {1'b0, paid} + {1'b0, coin_value(key_digit)};
    assign price_shift = money_t'(price % 7'd10) * 7'd10 + money_t'(key_digit);
    assign price_bcd   = money_to_bcd(price);
    assign paid_bcd    = money_to_bcd(paid);

    // registered rising edges of the clean button levels
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            set_d    <= 1'b0;
            pay_d    <= 1'b0;
            set_rise <= 1'b0;
            pay_rise <= 1'b0;
        end else begin
            set_d    <= btn_set;
            pay_d    <= btn_pay;
            set_rise <= btn_set & ~set_d;
            pay_rise <= btn_pay & ~pay_d;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= st_idle;
            led         <= led_off;
            stock       <= reset_stock;
            price       <= reset_price;
            paid        <= '0;
            price_field <= 1'b0;
            cnt         <= '0;
            phase       <= '0;
        end else begin
            case (state)
                st_idle: begin
                    led <= led_off;
                    if (set_rise) begin
                        state       <= st_set;
                        led         <= led_high;
                        price_field <= 1'b0;
                    end else if (pay_rise) begin
                        state <= st_payment;
                        paid  <= '0;
                    end
                end
                st_set: begin
                    if (space_hit) begin
                        price_field <= ~price_field;
                        led         <= price_field ? led_high : led_low;
                    end else if (digit_hit) begin
                        if (price_field) price <= price_shift;  // shift in from the right
                        else stock <= key_digit;
                    end else if (enter_hit) begin
                        state <= st_idle;
                    end
                end
                st_payment: begin
                    if (digit_hit) begin
                        if (key_digit == 4'd0) paid <= '0;
                        else if (coin_sum > {1'b0, money_max}) paid <= money_max;
                        else paid <= coin_sum[6:0];
                    end else if (enter_hit) begin
                        cnt   <= '0;
                        phase <= '0;
                        led   <= led_all;
                        if (paid >= price && stock != 4'd0) state <= st_buy;
                        else state <= st_change;  // refund
                    end
                end
                st_buy: begin
                    if (cnt == blink_last) begin
                        cnt <= '0;
                        if (phase == 3'd5) begin
                            state <= st_change;
                            led   <= led_all;
                        end else begin
                            phase <= phase + 3'd1;
                            led   <= ~led;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_change: begin
                    if (cnt == change_last) begin
                        cnt   <= '0;
                        state <= st_idle;
                        led   <= led_off;
                        stock <= stock - quantity;  // sold items leave the stock
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nums <= {4{digit_minus}};
        end else begin
            case (state)
                st_set:     nums <= {stock, digit_minus, price_bcd};
                st_payment: nums <= {digit_blank, digit_blank, paid_bcd};
                st_buy:     nums <= phase[0] ? {4{digit_blank}}
                                             : {quantity, digit_minus, spent_bcd};
                st_change:  nums <= {quantity, digit_minus, change_bcd};
                default:    nums <= {4{digit_minus}};
            endcase
        end
    end

    // stock only ever takes keypad digits or loses sold items
    assert property (@(posedge clk) disable iff (rst) stock <= 4'd9);

endmodule

`default_nettype wire

/* vend_pkg.sv */
`default_nettype none

package vend_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_set,
        st_payment,
        st_buy,
        st_change
    } vend_state_t;

    typedef enum logic [1:0] {
        kind_none,
        kind_digit,
        kind_enter,
        kind_space
    } key_kind_t;

    typedef logic [3:0]  bcd_t;    // one digit or display code
    typedef logic [6:0]  money_t;  // 0..99
    typedef logic [15:0] disp_t;   // four digit codes, leftmost on top

    localparam bcd_t digit_minus = 4'd10;
    localparam bcd_t digit_blank = 4'd11;

    localparam money_t money_max   = 7'd99;
    localparam money_t reset_price = 7'd10;
    localparam bcd_t   reset_stock = 4'd9;

    localparam logic [15:0] led_off  = 16'h0000;
    localparam logic [15:0] led_all  = 16'hffff;
    localparam logic [15:0] led_high = 16'hff00;
    localparam logic [15:0] led_low  = 16'h00ff;

    // value added by coin keys 1..4, other keys add nothing
    function automatic money_t coin_value(input bcd_t key);
        money_t value;
        case (key)
            4'd1:    value = 7'd1;
            4'd2:    value = 7'd5;
            4'd3:    value = 7'd10;
            4'd4:    value = 7'd50;
            default: value = 7'd0;
        endcase
        return value;
    endfunction

    // tens digit in the upper nibble
    function automatic logic [7:0] money_to_bcd(input money_t value);
        bcd_t tens;
        bcd_t units;
        tens  = bcd_t'(value / 7'd10);
        units = bcd_t'(value % 7'd10);
        return {tens, units};
    endfunction

endpackage

`default_nettype wire

/* vend_top.sv */
`timescale 1ns/1ns
`default_nettype none

module vend_top #(
    parameter int blink_cycles  = 25_000_000,
    parameter int change_cycles = 150_000_000,
    parameter int scan_div      = 16384
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        btn_set,
    input  logic        btn_pay,
    input  logic        key_valid,
    input  logic [8:0]  key_code,
    output logic [6:0]  seg,
    output logic [3:0]  digit,
    output logic [15:0] led
);
    import vend_pkg::*;

    logic        key_event;
    key_kind_t   key_kind;
    bcd_t        key_digit;
    vend_state_t state;
    money_t      price;
    bcd_t        stock;
    money_t      paid;
    bcd_t        quantity;
    logic [7:0]  spent_bcd;
    logic [7:0]  change_bcd;
    disp_t       nums;

    key_map i_key_map (
        .clk(clk), .rst(rst),
        .key_valid(key_valid), .key_code(key_code),
        .key_event(key_event), .key_kind(key_kind), .key_digit(key_digit)
    );

    vend_ctrl #(
        .blink_cycles(blink_cycles),
        .change_cycles(change_cycles)
    ) i_vend_ctrl (
        .clk(clk), .rst(rst), .btn_set(btn_set), .btn_pay(btn_pay),
        .key_event(key_event), .key_kind(key_kind), .key_digit(key_digit),
        .quantity(quantity), .spent_bcd(spent_bcd), .change_bcd(change_bcd),
        .state(state), .price(price), .stock(stock), .paid(paid),
        .nums(nums), .led(led)
    );

    purchase_calc i_purchase_calc (
        .clk(clk), .rst(rst), .state(state), .price(price), .stock(stock), .paid(paid),
        .quantity(quantity), .spent_bcd(spent_bcd), .change_bcd(change_bcd)
    );

    display_scan #(.scan_div(scan_div)) i_display_scan (
        .clk(clk), .rst(rst), .nums(nums), .seg(seg), .digit(digit)
    );

endmodule

`default_nettype wire

/* vlog.f */
vend_pkg.sv
key_map.sv
vend_ctrl.sv
purchase_calc.sv
display_scan.sv
vend_top.sv
tb_vend.sv
